// ==== hw/texmap_pkg.sv ====
// texture mapping shader constants

package texmap_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int SHADER_PARAM_WIDTH = 32;
	localparam int SHADER_PARAM_Q     = 24;
	localparam int SHADER_PARAM_NUM   = 3;

	// coordinate scale is 2**TEX_PHY_WIDTH texels per unit
	localparam int TEX_PHY_WIDTH   = 10;
	localparam int TEX_COORD_WIDTH = TEX_PHY_WIDTH + 2;

	localparam int INDEX_WIDTH  = 4;
	localparam int ADDR_WIDTH   = 32;
	localparam int SIZE_WIDTH   = 12;
	localparam int STRIDE_WIDTH = 16;

	localparam int WB_ADR_WIDTH = 6;
	localparam int WB_DAT_WIDTH = 32;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	localparam logic [WB_ADR_WIDTH-1:0] REG_PARAM_ADDR      = 6'h00;
	localparam logic [WB_ADR_WIDTH-1:0] REG_PARAM_WIDTH     = 6'h01;
	localparam logic [WB_ADR_WIDTH-1:0] REG_PARAM_HEIGHT    = 6'h02;
	localparam logic [WB_ADR_WIDTH-1:0] REG_PARAM_STRIDE_X  = 6'h05;
	localparam logic [WB_ADR_WIDTH-1:0] REG_PARAM_STRIDE_Y  = 6'h06;
	localparam logic [WB_ADR_WIDTH-1:0] REG_CFG_PARAM_NUM   = 6'h10;
	localparam logic [WB_ADR_WIDTH-1:0] REG_CFG_PARAM_WIDTH = 6'h11;
	localparam logic [WB_ADR_WIDTH-1:0] REG_CFG_PARAM_Q     = 6'h12;

	// reset values, 640x480 rgb888 raster
	localparam logic [ADDR_WIDTH-1:0]   INIT_ADDR     = '0;
	localparam logic [SIZE_WIDTH-1:0]   INIT_WIDTH    = 12'd640;
	localparam logic [SIZE_WIDTH-1:0]   INIT_HEIGHT   = 12'd480;
	localparam logic [STRIDE_WIDTH-1:0] INIT_STRIDE_X = 16'd3;
	localparam logic [STRIDE_WIDTH-1:0] INIT_STRIDE_Y = 16'd1920;

endpackage

// ==== hw/tex_param_if.sv ====
// texture parameter bundle

`timescale 1ns/1ps

interface tex_param_if;

	logic [texmap_pkg::ADDR_WIDTH-1:0]   addr;
	logic [texmap_pkg::SIZE_WIDTH-1:0]   width;
	logic [texmap_pkg::SIZE_WIDTH-1:0]   height;
	logic [texmap_pkg::STRIDE_WIDTH-1:0] stride_x;
	logic [texmap_pkg::STRIDE_WIDTH-1:0] stride_y;

	// shadow copy owner
	modport regs (
		output addr, width, height, stride_x, stride_y
	);

	modport gen (
		input addr, width, height, stride_x, stride_y
	);

endinterface

// ==== hw/persp_coord_if.sv ====
// perspective corrected coordinate lane

`timescale 1ns/1ps

interface persp_coord_if #(
	parameter int COORD_WIDTH = texmap_pkg::TEX_COORD_WIDTH,
	parameter int USER_WIDTH  = 1
);

	logic [COORD_WIDTH-1:0] coord;
	logic [USER_WIDTH-1:0]  user;
	logic                   valid;

	// divider side
	modport lane (
		output coord,
		output user,
		output valid
	);

	// address generator side
	modport gen (
		input coord,
		input user,
		input valid
	);

endinterface

// ==== hw/texmap_regs.sv ====
// texture parameter register file

`timescale 1ns/1ps

module texmap_regs (
	input  logic                                clk,
	input  logic                                s_wb_rst_i,
	input  logic [texmap_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i,
	input  logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_i,
	output logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_o,
	input  logic                                s_wb_we_i,
	input  logic [3:0]                          s_wb_sel_i,
	input  logic                                s_wb_stb_i,
	output logic                                s_wb_ack_o,
	input  logic                                update_i,
	tex_param_if.regs                           param
);

	localparam int DW = texmap_pkg::WB_DAT_WIDTH;
	localparam int AW = texmap_pkg::ADDR_WIDTH;
	localparam int SW = texmap_pkg::SIZE_WIDTH;
	localparam int TW = texmap_pkg::STRIDE_WIDTH;

	logic [AW-1:0] reg_addr;
	logic [SW-1:0] reg_width;
	logic [SW-1:0] reg_height;
	logic [TW-1:0] reg_stride_x;
	logic [TW-1:0] reg_stride_y;

	logic [DW-1:0] wb_mask;
	logic          wb_write;

	function automatic logic [DW-1:0] wb_merge(
		input logic [DW-1:0] old_val,
		input logic [DW-1:0] new_val,
		input logic [DW-1:0] mask
	);
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	// byte lanes from sel
	assign wb_mask  = {{8{s_wb_sel_i[3]}}, {8{s_wb_sel_i[2]}},
	                   {8{s_wb_sel_i[1]}}, {8{s_wb_sel_i[0]}}};
	assign wb_write = s_wb_stb_i && s_wb_we_i;

	// --------------------------------------------------
	// writable parameters
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			reg_addr     <= texmap_pkg::INIT_ADDR;
			reg_width    <= texmap_pkg::INIT_WIDTH;
			reg_height   <= texmap_pkg::INIT_HEIGHT;
			reg_stride_x <= texmap_pkg::INIT_STRIDE_X;
			reg_stride_y <= texmap_pkg::INIT_STRIDE_Y;
		end else if (wb_write) begin
			case (s_wb_adr_i)
				texmap_pkg::REG_PARAM_ADDR:
					reg_addr <= AW'(wb_merge(DW'(reg_addr), s_wb_dat_i, wb_mask));
				texmap_pkg::REG_PARAM_WIDTH:
					reg_width <= SW'(wb_merge(DW'(reg_width), s_wb_dat_i, wb_mask));
				texmap_pkg::REG_PARAM_HEIGHT:
					reg_height <= SW'(wb_merge(DW'(reg_height), s_wb_dat_i, wb_mask));
				texmap_pkg::REG_PARAM_STRIDE_X:
					reg_stride_x <= TW'(wb_merge(DW'(reg_stride_x), s_wb_dat_i, wb_mask));
				texmap_pkg::REG_PARAM_STRIDE_Y:
					reg_stride_y <= TW'(wb_merge(DW'(reg_stride_y), s_wb_dat_i, wb_mask));
				default: ;
			endcase
		end
	end

	// read decode, config words are constants
	always_comb begin
		s_wb_dat_o = '0;
		case (s_wb_adr_i)
			texmap_pkg::REG_PARAM_ADDR:      s_wb_dat_o = DW'(reg_addr);
			texmap_pkg::REG_PARAM_WIDTH:     s_wb_dat_o = DW'(reg_width);
			texmap_pkg::REG_PARAM_HEIGHT:    s_wb_dat_o = DW'(reg_height);
			texmap_pkg::REG_PARAM_STRIDE_X:  s_wb_dat_o = DW'(reg_stride_x);
			texmap_pkg::REG_PARAM_STRIDE_Y:  s_wb_dat_o = DW'(reg_stride_y);
			texmap_pkg::REG_CFG_PARAM_NUM:   s_wb_dat_o = DW'(texmap_pkg::SHADER_PARAM_NUM);
			texmap_pkg::REG_CFG_PARAM_WIDTH: s_wb_dat_o = DW'(texmap_pkg::SHADER_PARAM_WIDTH);
			texmap_pkg::REG_CFG_PARAM_Q:     s_wb_dat_o = DW'(texmap_pkg::SHADER_PARAM_Q);
			default:                         s_wb_dat_o = '0;
		endcase
	end

	assign s_wb_ack_o = s_wb_stb_i;

	// --------------------------------------------------
	// shadow copy seen by the pipeline
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			param.addr     <= texmap_pkg::INIT_ADDR;
			param.width    <= texmap_pkg::INIT_WIDTH;
			param.height   <= texmap_pkg::INIT_HEIGHT;
			param.stride_x <= texmap_pkg::INIT_STRIDE_X;
			param.stride_y <= texmap_pkg::INIT_STRIDE_Y;
		end else if (update_i) begin
			param.addr     <= reg_addr;
			param.width    <= reg_width;
			param.height   <= reg_height;
			param.stride_x <= reg_stride_x;
			param.stride_y <= reg_stride_y;
		end
	end

	// single cycle wishbone handshake
	a_ack_is_stb: assert property (@(posedge clk) s_wb_ack_o == s_wb_stb_i)
		else $error("wishbone ack does not follow stb");

endmodule

// ==== hw/persp_divider.sv ====
// pipelined perspective divider

`timescale 1ns/1ps

module persp_divider #(
	parameter int COORD_WIDTH = texmap_pkg::TEX_COORD_WIDTH,
	parameter int USER_WIDTH  = 1
) (
	input  logic                                             clk,
	input  logic                                             s_wb_rst_i,
	input  logic                                             cke_i,
	input  logic signed [texmap_pkg::SHADER_PARAM_WIDTH-1:0] s_dividend_i,
	input  logic signed [texmap_pkg::SHADER_PARAM_WIDTH-1:0] s_divisor_i,
	input  logic [USER_WIDTH-1:0]                            s_user_i,
	input  logic                                             s_valid_i,
	persp_coord_if.lane                                      m
);

	localparam int PW = texmap_pkg::SHADER_PARAM_WIDTH;
	// remainder must hold divisor shifted by the full quotient width
	localparam int RW = PW + COORD_WIDTH;

	logic [RW-1:0] in_num;
	logic [RW-1:0] in_lim;
	logic          in_sat;

	logic [RW-1:0]          rem_q  [0:COORD_WIDTH-1];
	logic [PW-1:0]          den_q  [0:COORD_WIDTH-1];
	logic [COORD_WIDTH-1:0] quo_q  [1:COORD_WIDTH];
	logic                   sat_q  [0:COORD_WIDTH];
	logic [USER_WIDTH-1:0]  user_q [0:COORD_WIDTH];
	logic [COORD_WIDTH:0]   valid_q;

	logic [RW-1:0]          trial [0:COORD_WIDTH-1];
	logic [COORD_WIDTH-1:0] fit;

	// --------------------------------------------------
	// input stage
	// --------------------------------------------------
	always_comb begin
		// negative u or v maps to texel 0
		if (s_dividend_i[PW-1]) begin
			in_num = '0;
		end else begin
			in_num = RW'($unsigned(s_dividend_i)) << texmap_pkg::TEX_PHY_WIDTH;
		end
		in_lim = RW'($unsigned(s_divisor_i)) << COORD_WIDTH;
		in_sat = (in_num >= in_lim);
	end

	// one quotient bit per stage, msb first
	always_comb begin
		for (int k = 0; k < COORD_WIDTH; k++) begin
			trial[k] = RW'(den_q[k]) << (COORD_WIDTH - 1 - k);
			fit[k]   = (rem_q[k] >= trial[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			valid_q <= '0;
		end else if (cke_i) begin
			valid_q <= {valid_q[COORD_WIDTH-1:0], s_valid_i};
		end
	end

	always_ff @(posedge clk) begin
		if (cke_i) begin
			rem_q[0]  <= in_num;
			den_q[0]  <= $unsigned(s_divisor_i);
			sat_q[0]  <= in_sat;
			user_q[0] <= s_user_i;
			quo_q[1]  <= COORD_WIDTH'(fit[0]) << (COORD_WIDTH - 1);
			for (int k = 0; k < COORD_WIDTH; k++) begin
				sat_q[k+1]  <= sat_q[k];
				user_q[k+1] <= user_q[k];
			end
			for (int k = 1; k < COORD_WIDTH; k++) begin
				quo_q[k+1] <= quo_q[k] | (COORD_WIDTH'(fit[k]) << (COORD_WIDTH - 1 - k));
			end
			for (int k = 0; k + 1 < COORD_WIDTH; k++) begin
				rem_q[k+1] <= fit[k] ? (rem_q[k] - trial[k]) : rem_q[k];
				den_q[k+1] <= den_q[k];
			end
		end
	end

	assign m.coord = sat_q[COORD_WIDTH] ? '1 : quo_q[COORD_WIDTH];
	assign m.user  = user_q[COORD_WIDTH];
	assign m.valid = valid_q[COORD_WIDTH];

	// z of zero has no defined quotient
	a_z_nonzero: assert property (
		@(posedge clk) disable iff (s_wb_rst_i)
		(s_valid_i && cke_i) |-> (s_divisor_i != '0)
	) else $error("zero depth accepted by divider");

endmodule

// ==== hw/texel_addr_gen.sv ====
// texel address generator

`timescale 1ns/1ps

module texel_addr_gen #(
	parameter int COORD_WIDTH = texmap_pkg::TEX_COORD_WIDTH
) (
	input  logic                               clk,
	input  logic                               s_wb_rst_i,
	input  logic                               cke_i,
	persp_coord_if.gen                         u,
	persp_coord_if.gen                         v,
	tex_param_if.gen                           param,
	output logic [texmap_pkg::ADDR_WIDTH-1:0]  m_addr_o,
	output logic                               m_frame_start_o,
	output logic                               m_line_end_o,
	output logic                               m_polygon_enable_o,
	output logic [texmap_pkg::INDEX_WIDTH-1:0] m_polygon_index_o,
	output logic                               m_valid_o
);

	localparam int AW = texmap_pkg::ADDR_WIDTH;
	localparam int IW = texmap_pkg::INDEX_WIDTH;
	// common width for the clamp compare
	localparam int LW = (COORD_WIDTH > texmap_pkg::SIZE_WIDTH) ?
	                    COORD_WIDTH : texmap_pkg::SIZE_WIDTH;

	logic [LW-1:0] x_max;
	logic [LW-1:0] y_max;
	logic [LW-1:0] x_clamp;
	logic [LW-1:0] y_clamp;
	logic [AW-1:0] addr_next;

	always_comb begin
		x_max   = LW'(param.width) - LW'(1);
		y_max   = LW'(param.height) - LW'(1);
		x_clamp = (LW'(u.coord) > x_max) ? x_max : LW'(u.coord);
		y_clamp = (LW'(v.coord) > y_max) ? y_max : LW'(v.coord);
		// wraps at the address width
		addr_next = param.addr
		          + AW'(x_clamp) * AW'(param.stride_x)
		          + AW'(y_clamp) * AW'(param.stride_y);
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (s_wb_rst_i) begin
			m_valid_o <= 1'b0;
		end else if (cke_i) begin
			m_valid_o <= u.valid && v.valid;
		end
	end

	// u lane user is {frame_start, line_end, enable, index}
	always_ff @(posedge clk) begin
		if (cke_i) begin
			m_addr_o           <= addr_next;
			m_frame_start_o    <= u.user[IW+2];
			m_line_end_o       <= u.user[IW+1];
			m_polygon_enable_o <= u.user[IW] & v.user[0];
			m_polygon_index_o  <= u.user[IW-1:0];
		end
	end

	// both lanes have the same depth so their valids line up
	a_lanes_aligned: assert property (
		@(posedge clk) disable iff (s_wb_rst_i) u.valid == v.valid
	) else $error("u and v divider lanes out of step");

endmodule

// ==== hw/texmap_shader.sv ====
// texture mapping shader front end

`timescale 1ns/1ps

module texmap_shader #(
	parameter int COORD_WIDTH = texmap_pkg::TEX_COORD_WIDTH
) (
	input  logic                                clk,
	input  logic                                s_wb_rst_i,

	// wishbone
	input  logic [texmap_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i,
	input  logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_i,
	output logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_o,
	input  logic                                s_wb_we_i,
	input  logic [3:0]                          s_wb_sel_i,
	input  logic                                s_wb_stb_i,
	output logic                                s_wb_ack_o,

	input  logic                                update_i,

	// rasterizer
	input  logic                                s_frame_start_i,
	input  logic                                s_line_end_i,
	input  logic                                s_polygon_enable_i,
	input  logic [texmap_pkg::INDEX_WIDTH-1:0]  s_polygon_index_i,
	input  logic [texmap_pkg::SHADER_PARAM_NUM*texmap_pkg::SHADER_PARAM_WIDTH-1:0]
	                                            s_shader_params_i,
	input  logic                                s_valid_i,
	output logic                                s_ready_o,

	// texel address
	output logic [texmap_pkg::ADDR_WIDTH-1:0]   m_addr_o,
	output logic                                m_frame_start_o,
	output logic                                m_line_end_o,
	output logic                                m_polygon_enable_o,
	output logic [texmap_pkg::INDEX_WIDTH-1:0]  m_polygon_index_o,
	output logic                                m_valid_o,
	input  logic                                m_ready_i
);

	localparam int PW      = texmap_pkg::SHADER_PARAM_WIDTH;
	localparam int U_USER  = 3 + texmap_pkg::INDEX_WIDTH;
	localparam int V_USER  = 1;

	logic cke;

	// whole pipeline stalls with the output
	assign cke       = m_ready_i;
	assign s_ready_o = m_ready_i;

	tex_param_if i_param_if ();
	persp_coord_if #(.COORD_WIDTH(COORD_WIDTH), .USER_WIDTH(U_USER)) i_coord_u ();
	persp_coord_if #(.COORD_WIDTH(COORD_WIDTH), .USER_WIDTH(V_USER)) i_coord_v ();

	texmap_regs i_regs (
		.clk        (clk),
		.s_wb_rst_i (s_wb_rst_i),
		.s_wb_adr_i (s_wb_adr_i),
		.s_wb_dat_i (s_wb_dat_i),
		.s_wb_dat_o (s_wb_dat_o),
		.s_wb_we_i  (s_wb_we_i),
		.s_wb_sel_i (s_wb_sel_i),
		.s_wb_stb_i (s_wb_stb_i),
		.s_wb_ack_o (s_wb_ack_o),
		.update_i   (update_i),
		.param      (i_param_if.regs)
	);

	// --------------------------------------------------
	// u/z and v/z lanes, z is the low word
	// --------------------------------------------------
	persp_divider #(.COORD_WIDTH(COORD_WIDTH), .USER_WIDTH(U_USER)) i_div_u (
		.clk          (clk),
		.s_wb_rst_i   (s_wb_rst_i),
		.cke_i        (cke),
		.s_dividend_i ($signed(s_shader_params_i[2*PW-1:PW])),
		.s_divisor_i  ($signed(s_shader_params_i[PW-1:0])),
		.s_user_i     ({s_frame_start_i, s_line_end_i, s_polygon_enable_i, s_polygon_index_i}),
		.s_valid_i    (s_valid_i),
		.m            (i_coord_u.lane)
	);

	persp_divider #(.COORD_WIDTH(COORD_WIDTH), .USER_WIDTH(V_USER)) i_div_v (
		.clk          (clk),
		.s_wb_rst_i   (s_wb_rst_i),
		.cke_i        (cke),
		.s_dividend_i ($signed(s_shader_params_i[3*PW-1:2*PW])),
		.s_divisor_i  ($signed(s_shader_params_i[PW-1:0])),
		.s_user_i     (s_polygon_enable_i),
		.s_valid_i    (s_valid_i),
		.m            (i_coord_v.lane)
	);

	texel_addr_gen #(.COORD_WIDTH(COORD_WIDTH)) i_addr_gen (
		.clk                (clk),
		.s_wb_rst_i         (s_wb_rst_i),
		.cke_i              (cke),
		.u                  (i_coord_u.gen),
		.v                  (i_coord_v.gen),
		.param              (i_param_if.gen),
		.m_addr_o           (m_addr_o),
		.m_frame_start_o    (m_frame_start_o),
		.m_line_end_o       (m_line_end_o),
		.m_polygon_enable_o (m_polygon_enable_o),
		.m_polygon_index_o  (m_polygon_index_o),
		.m_valid_o          (m_valid_o)
	);

endmodule

// ==== verif/tb_texmap_shader.sv ====
// texture shader testbench

`timescale 1ns/1ps

module tb_texmap_shader;

	localparam int PW          = texmap_pkg::SHADER_PARAM_WIDTH;
	localparam int IW          = texmap_pkg::INDEX_WIDTH;
	localparam int AW          = texmap_pkg::ADDR_WIDTH;
	localparam int ITEM_W      = AW + 3 + IW;
	localparam int LATENCY     = texmap_pkg::TEX_COORD_WIDTH + 2;
	localparam int CYCLE_LIMIT = 20000;

	logic                                clk;
	logic                                s_wb_rst_i;
	logic [texmap_pkg::WB_ADR_WIDTH-1:0] s_wb_adr_i;
	logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_i;
	logic [texmap_pkg::WB_DAT_WIDTH-1:0] s_wb_dat_o;
	logic                                s_wb_we_i;
	logic [3:0]                          s_wb_sel_i;
	logic                                s_wb_stb_i;
	logic                                s_wb_ack_o;
	logic                                update_i;
	logic                                s_frame_start_i;
	logic                                s_line_end_i;
	logic                                s_polygon_enable_i;
	logic [IW-1:0]                       s_polygon_index_i;
	logic [3*PW-1:0]                     s_shader_params_i;
	logic                                s_valid_i;
	logic                                s_ready_o;
	logic [AW-1:0]                       m_addr_o;
	logic                                m_frame_start_o;
	logic                                m_line_end_o;
	logic                                m_polygon_enable_o;
	logic [IW-1:0]                       m_polygon_index_o;
	logic                                m_valid_o;
	logic                                m_ready_i;

	// expected items in output order
	logic [ITEM_W-1:0] exp_q [$];
	logic [ITEM_W-1:0] got_item;
	logic [ITEM_W-1:0] want_item;

	// shadow copy as the pipeline sees it, and the written registers
	logic [31:0] sh_addr;
	logic [11:0] sh_width;
	logic [11:0] sh_height;
	logic [15:0] sh_stride_x;
	logic [15:0] sh_stride_y;
	logic [31:0] pend_addr;
	logic [11:0] pend_width;
	logic [11:0] pend_height;
	logic [15:0] pend_stride_x;
	logic [15:0] pend_stride_y;

	int   error_count;
	int   items_checked;
	int   tests_run;
	int   test_start_errors;
	int   cycle_count;
	int   item_start;
	int   n;
	logic seen;
	logic bp_mode;

	texmap_shader i_texmap_shader (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic note_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
	endtask

	// floor(u * 2**phy / z), negative gives 0, saturates at the coordinate width
	function automatic logic [31:0] coord_model(input logic [31:0] num, input logic [31:0] z);
		logic [63:0] q;
		if (num[31])
			return 32'd0;
		q = ({32'd0, num} << texmap_pkg::TEX_PHY_WIDTH) / {32'd0, z};
		if (q >= (64'd1 << texmap_pkg::TEX_COORD_WIDTH))
			return (32'd1 << texmap_pkg::TEX_COORD_WIDTH) - 1;
		return q[31:0];
	endfunction

	function automatic logic [ITEM_W-1:0] expect_item(
		input logic [31:0] u,
		input logic [31:0] v,
		input logic [31:0] z,
		input logic        fs,
		input logic        le,
		input logic        pe,
		input logic [IW-1:0] idx
	);
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] a;
		x = coord_model(u, z);
		y = coord_model(v, z);
		if (x > 32'(sh_width) - 1)
			x = 32'(sh_width) - 1;
		if (y > 32'(sh_height) - 1)
			y = 32'(sh_height) - 1;
		a = sh_addr + x * 32'(sh_stride_x) + y * 32'(sh_stride_y);
		return {a, fs, le, pe, idx};
	endfunction

	// --------------------------------------------------
	// wishbone and stream drivers
	// --------------------------------------------------
	task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat);
		@(negedge clk);
		s_wb_adr_i = adr;
		s_wb_dat_i = dat;
		s_wb_sel_i = 4'hf;
		s_wb_we_i  = 1'b1;
		s_wb_stb_i = 1'b1;
		@(negedge clk);
		s_wb_stb_i = 1'b0;
		s_wb_we_i  = 1'b0;
	endtask

	task automatic read_check(input logic [5:0] adr, input logic [31:0] want, input string what);
		logic [31:0] data;
		@(negedge clk);
		s_wb_adr_i = adr;
		s_wb_we_i  = 1'b0;
		s_wb_stb_i = 1'b1;
		@(posedge clk);
		data = s_wb_dat_o;
		assert (s_wb_ack_o) else note_error("no acknowledge on a wishbone read");
		assert (data === want)
			else note_error($sformatf("%s read %h, expected %h", what, data, want));
		@(negedge clk);
		s_wb_stb_i = 1'b0;
	endtask

	task automatic write_params(input logic [31:0] a, input logic [11:0] w, input logic [11:0] h,
	                            input logic [15:0] sx, input logic [15:0] sy);
		wb_write(texmap_pkg::REG_PARAM_ADDR, a);
		wb_write(texmap_pkg::REG_PARAM_WIDTH, 32'(w));
		wb_write(texmap_pkg::REG_PARAM_HEIGHT, 32'(h));
		wb_write(texmap_pkg::REG_PARAM_STRIDE_X, 32'(sx));
		wb_write(texmap_pkg::REG_PARAM_STRIDE_Y, 32'(sy));
		pend_addr     = a;
		pend_width    = w;
		pend_height   = h;
		pend_stride_x = sx;
		pend_stride_y = sy;
	endtask

	// only called with the pipeline empty
	task automatic pulse_update;
		@(negedge clk);
		update_i = 1'b1;
		@(negedge clk);
		update_i    = 1'b0;
		sh_addr     = pend_addr;
		sh_width    = pend_width;
		sh_height   = pend_height;
		sh_stride_x = pend_stride_x;
		sh_stride_y = pend_stride_y;
	endtask

	// returns on the accepting edge with valid still high
	task automatic send_item(input logic [31:0] u, input logic [31:0] v, input logic [31:0] z,
	                         input logic fs, input logic le, input logic pe,
	                         input logic [IW-1:0] idx);
		@(negedge clk);
		s_shader_params_i  = {v, u, z};
		s_frame_start_i    = fs;
		s_line_end_i       = le;
		s_polygon_enable_i = pe;
		s_polygon_index_i  = idx;
		s_valid_i          = 1'b1;
		@(posedge clk);
		while (!s_ready_o)
			@(posedge clk);
	endtask

	task automatic send_random_item;
		logic [31:0] z;
		logic [31:0] u;
		logic [31:0] v;
		z = $urandom_range(32'h0400_0000, 32'h0010_0000);
		u = $urandom_range(32'h0200_0000, 0);
		v = $urandom_range(32'h0200_0000, 0);
		if ($urandom_range(7, 0) == 0)
			u = -u;
		if ($urandom_range(7, 0) == 0)
			v = -v;
		send_item(u, v, z, 1'($urandom), 1'($urandom), 1'($urandom), IW'($urandom));
	endtask

	task automatic wait_drain;
		@(negedge clk);
		s_valid_i = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	// random ready in back-pressure phases
	always @(negedge clk) begin
		if (bp_mode)
			m_ready_i = 1'($urandom % 2);
		else
			m_ready_i = 1'b1;
	end

	// --------------------------------------------------
	// model queue and output compare
	// --------------------------------------------------
	always @(posedge clk) begin
		if (!s_wb_rst_i) begin
			if (s_valid_i && s_ready_o) begin
				exp_q.push_back(expect_item(s_shader_params_i[2*PW-1:PW],
					s_shader_params_i[3*PW-1:2*PW], s_shader_params_i[PW-1:0],
					s_frame_start_i, s_line_end_i, s_polygon_enable_i, s_polygon_index_i));
			end
			if (m_valid_o && m_ready_i) begin
				// every output handshake counts, so extra outputs show in the totals
				items_checked++;
				assert (exp_q.size() != 0) else note_error("texel output with no accepted input");
				if (exp_q.size() != 0) begin
					want_item = exp_q.pop_front();
					got_item  = {m_addr_o, m_frame_start_o, m_line_end_o,
					             m_polygon_enable_o, m_polygon_index_o};
					assert (got_item === want_item)
						else note_error($sformatf("item %0d addr %h flags %b, expected %h flags %b",
							items_checked, got_item[ITEM_W-1 -: AW], got_item[IW+2:0],
							want_item[ITEM_W-1 -: AW], want_item[IW+2:0]));
				end
			end
		end
	end

	a_ack_follows_stb: assert property (@(posedge clk) s_wb_ack_o == s_wb_stb_i)
		else note_error("wishbone ack differs from stb");

	a_ready_follows: assert property (@(posedge clk) s_ready_o == m_ready_i)
		else note_error("s_ready_o differs from m_ready_i");

	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (s_wb_rst_i)
		(!m_ready_i && m_valid_o) |=> (m_valid_o && $stable(m_addr_o))
	) else note_error("output changed while m_ready_i was low");

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		void'($urandom(51));
		s_wb_rst_i         = 1'b1;
		s_wb_adr_i         = '0;
		s_wb_dat_i         = '0;
		s_wb_we_i          = 1'b0;
		s_wb_sel_i         = 4'h0;
		s_wb_stb_i         = 1'b0;
		update_i           = 1'b0;
		s_frame_start_i    = 1'b0;
		s_line_end_i       = 1'b0;
		s_polygon_enable_i = 1'b0;
		s_polygon_index_i  = '0;
		s_shader_params_i  = '0;
		s_valid_i          = 1'b0;
		m_ready_i          = 1'b1;
		bp_mode            = 1'b0;
		sh_addr            = 32'd0;
		sh_width           = 12'd640;
		sh_height          = 12'd480;
		sh_stride_x        = 16'd3;
		sh_stride_y        = 16'd1920;
		pend_addr          = sh_addr;
		pend_width         = sh_width;
		pend_height        = sh_height;
		pend_stride_x      = sh_stride_x;
		pend_stride_y      = sh_stride_y;
		repeat (10) @(posedge clk);
		@(negedge clk);
		s_wb_rst_i = 1'b0;

		// single item latency, straight after reset
		test_start_errors = error_count;
		repeat (3) begin
			@(posedge clk);
			assert (!m_valid_o) else note_error("m_valid_o high after reset with no input");
		end
		send_item(32'h0080_0000, 32'h0040_0000, 32'h0100_0000, 1'b1, 1'b0, 1'b1, 4'h5);
		@(negedge clk);
		s_valid_i = 1'b0;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 4 * LATENCY) begin
			@(posedge clk);
			n++;
			seen = m_valid_o;
		end
		assert (n == LATENCY)
			else note_error($sformatf("latency %0d cycles, expected %0d", n, LATENCY));
		wait_drain();
		finish_test("latency");

		test_start_errors = error_count;
		read_check(texmap_pkg::REG_PARAM_ADDR, 32'd0, "addr init");
		read_check(texmap_pkg::REG_PARAM_WIDTH, 32'd640, "width init");
		read_check(texmap_pkg::REG_PARAM_HEIGHT, 32'd480, "height init");
		read_check(texmap_pkg::REG_PARAM_STRIDE_X, 32'd3, "stride x init");
		read_check(texmap_pkg::REG_PARAM_STRIDE_Y, 32'd1920, "stride y init");
		read_check(texmap_pkg::REG_CFG_PARAM_NUM, 32'd3, "param num");
		read_check(texmap_pkg::REG_CFG_PARAM_WIDTH, 32'd32, "param width");
		read_check(texmap_pkg::REG_CFG_PARAM_Q, 32'd24, "param q");
		read_check(6'h3f, 32'd0, "unmapped");
		write_params(32'h0012_3400, 12'd800, 12'd600, 16'd4, 16'd3200);
		read_check(texmap_pkg::REG_PARAM_ADDR, 32'h0012_3400, "addr");
		read_check(texmap_pkg::REG_PARAM_WIDTH, 32'd800, "width");
		read_check(texmap_pkg::REG_PARAM_HEIGHT, 32'd600, "height");
		read_check(texmap_pkg::REG_PARAM_STRIDE_X, 32'd4, "stride x");
		read_check(texmap_pkg::REG_PARAM_STRIDE_Y, 32'd3200, "stride y");
		wb_write(texmap_pkg::REG_CFG_PARAM_NUM, 32'hdead_beef);
		wb_write(texmap_pkg::REG_CFG_PARAM_Q, 32'h0000_0007);
		read_check(texmap_pkg::REG_CFG_PARAM_NUM, 32'd3, "param num after write");
		read_check(texmap_pkg::REG_CFG_PARAM_Q, 32'd24, "param q after write");
		finish_test("register file");

		test_start_errors = error_count;
		write_params(32'h1000_0000, 12'd1100, 12'd900, 16'd4, 16'd8000);
		pulse_update();
		item_start = items_checked;
		repeat (200) send_random_item();
		wait_drain();
		assert (items_checked - item_start == 200) else note_error("random items went missing");
		finish_test("address rule");

		test_start_errors = error_count;
		write_params(32'h0000_8000, 12'd640, 12'd480, 16'd3, 16'd1920);
		pulse_update();
		send_item(32'hfd00_0000, 32'h0080_0000, 32'h0100_0000, 1'b0, 1'b1, 1'b1, 4'h1);
		send_item(32'h0040_0000, 32'hff80_0000, 32'h0100_0000, 1'b1, 1'b0, 1'b0, 4'h2);
		send_item(32'h0300_0000, 32'h0200_0000, 32'h0100_0000, 1'b0, 1'b0, 1'b1, 4'h3);
		send_item(32'h1400_0000, 32'h7fff_ffff, 32'h0100_0000, 1'b1, 1'b1, 1'b1, 4'hf);
		send_item(32'h0000_0001, 32'h0000_0002, 32'h0000_0001, 1'b0, 1'b1, 1'b0, 4'h8);
		wait_drain();
		finish_test("clamping");

		test_start_errors = error_count;
		write_params(32'h0000_2000, 12'd256, 12'd256, 16'd2, 16'd512);
		pulse_update();
		repeat (4) send_random_item();
		wait_drain();
		// registers change, shadow stays
		write_params(32'h0004_0000, 12'd128, 12'd64, 16'd8, 16'd1024);
		repeat (4) send_random_item();
		wait_drain();
		pulse_update();
		repeat (4) send_random_item();
		wait_drain();
		finish_test("shadow update");

		test_start_errors = error_count;
		bp_mode = 1'b1;
		item_start = items_checked;
		repeat (150) send_random_item();
		wait_drain();
		bp_mode = 1'b0;
		assert (items_checked - item_start == 150) else note_error("items lost under back-pressure");
		finish_test("back-pressure");

		$display("tests %0d, items checked %0d, errors %0d", tests_run, items_checked, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== src.f ====
hw/texmap_pkg.sv
hw/tex_param_if.sv
hw/persp_coord_if.sv
hw/texmap_regs.sv
hw/persp_divider.sv
hw/texel_addr_gen.sv
hw/texmap_shader.sv
verif/tb_texmap_shader.sv

// ==== Bender.yml ====
package:
  name: texmap_shader

sources:
  - hw/texmap_pkg.sv
  - hw/tex_param_if.sv
  - hw/persp_coord_if.sv
  - hw/texmap_regs.sv
  - hw/persp_divider.sv
  - hw/texel_addr_gen.sv
  - hw/texmap_shader.sv
  - target: test
    files:
      - verif/tb_texmap_shader.sv
